// File: verilog.f
src/vga_pkg.sv
src/vga_timing.sv
src/draw_bg.sv
src/char_ctrl.sv
src/draw_char.sv
src/game_regs.sv
src/top_vga.sv
sim/top_vga_sva.sv
sim/top_vga_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run; exit status reports pass or fail
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module top_vga_tb \
    -f verilog.f -o top_vga_tb_sim &&
./obj_dir/top_vga_tb_sim || exit 1

// File: sim/top_vga_tb.sv
`timescale 1ns/1ps

module top_vga_tb;
    import vga_pkg::*;

    localparam int H_ACTIVE = 64, H_FP = 4, H_SYNC = 8, H_BP = 4;
    localparam int V_ACTIVE = 48, V_FP = 2, V_SYNC = 3, V_BP = 3;
    localparam int CHAR_W = 8, CHAR_H = 8, GY_INIT = 40;
    localparam int H_TOTAL = H_ACTIVE + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL = V_ACTIVE + V_FP + V_SYNC + V_BP;
    localparam int FRAME_LEN = H_TOTAL * V_TOTAL;
    localparam int N_FRAMES = 90;

    logic clk, rst_n, left, right, jump, hs, vs, on_ground;
    logic [3:0] r, g, b;
    logic [10:0] char_x, char_y;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;
    integer seed = 32'h8786_ade2;

    top_vga #(
        .H_ACTIVE(H_ACTIVE), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
        .V_ACTIVE(V_ACTIVE), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP),
        .CHAR_W(CHAR_W), .CHAR_H(CHAR_H), .GROUND_Y_INIT(GY_INIT)
    ) u_dut (
        .clk(clk), .rst_n(rst_n), .stepleft(left), .stepright(right), .stepjump(jump),
        .wb_req(wb_req), .wb_rsp(wb_rsp), .hs(hs), .vs(vs), .r(r), .g(g), .b(b),
        .on_ground(on_ground), .char_x(char_x), .char_y(char_y)
    );

    // --------------------------------------------------
    // reference model
    // --------------------------------------------------
    int mh, mv, mx, my, mvel, mcnt;
    logic mft, mack, mair, mog, srun;
    rgb_t sbg, sgc, scc;
    logic [10:0] sgy;
    logic [3:0] sstep, sjump;
    vga_sig_t t0, s1, s2;
    rgb_t bg_rgb, ch_rgb;
    logic macc;

    assign macc = wb_req.cyc && wb_req.stb && !mack;

    always_comb begin
        t0 = '0;
        t0.hcount = 11'(mh);
        t0.vcount = 11'(mv);
        t0.hsync  = (mh >= H_ACTIVE + H_FP) && (mh < H_ACTIVE + H_FP + H_SYNC);
        t0.vsync  = (mv >= V_ACTIVE + V_FP) && (mv < V_ACTIVE + V_FP + V_SYNC);
        t0.hblnk  = (mh >= H_ACTIVE);
        t0.vblnk  = (mv >= V_ACTIVE);
        bg_rgb = (t0.hblnk || t0.vblnk) ? rgb_t'(0) : ((t0.vcount >= sgy) ? sgc : sbg);
        ch_rgb = s1.rgb;
        if (srun && !s1.hblnk && !s1.vblnk && int'(s1.hcount) >= mx
            && int'(s1.hcount) < mx + CHAR_W && int'(s1.vcount) >= my
            && int'(s1.vcount) < my + CHAR_H) begin
            ch_rgb = scc;
        end
    end

    always @(posedge clk or negedge rst_n) begin
        int nh, nv, land, nx, ny, nvel, ysum;
        logic nair;
        if (!rst_n) begin
            mh <= 0;
            mv <= 0;
            mft <= 0;
            mack <= 0;
            mcnt <= 0;
            s1 <= '0;
            s2 <= '0;
            srun <= 0;
            sbg <= '0;
            sgc <= '0;
            scc <= '0;
            sgy <= 11'(GY_INIT);
            sstep <= 4'd1;
            sjump <= 4'd4;
            mx <= 0;
            my <= GY_INIT - CHAR_H;
            mvel <= 0;
            mair <= 0;
            mog <= 0;
        end else begin
            nh = (mh == H_TOTAL - 1) ? 0 : mh + 1;
            nv = (mh != H_TOTAL - 1) ? mv : ((mv == V_TOTAL - 1) ? 0 : mv + 1);
            mh <= nh;
            mv <= nv;
            mft <= (nh == 0) && (nv == V_ACTIVE);
            s1 <= t0;
            s1.rgb <= bg_rgb;
            s2 <= s1;
            s2.rgb <= ch_rgb;
            mack <= macc;
            if (macc && wb_req.we) begin
                case (wb_req.adr)
                    4'd0: srun <= wb_req.dat_w[0];
                    4'd1: sbg <= wb_req.dat_w[11:0];
                    4'd2: sgc <= wb_req.dat_w[11:0];
                    4'd3: scc <= wb_req.dat_w[11:0];
                    4'd4: sgy <= wb_req.dat_w[10:0];
                    4'd5: begin
                        sstep <= wb_req.dat_w[3:0];
                        sjump <= wb_req.dat_w[11:8];
                    end
                    default: ;
                endcase
            end
            if (mft) mcnt <= mcnt + 1;
            if (mft && srun) begin      // motion rules in order
                land = int'(sgy) - CHAR_H;
                nx = mx;
                if (left && !right && mx >= int'(sstep)) nx = mx - int'(sstep);
                else if (right && !left && mx + int'(sstep) <= H_ACTIVE - CHAR_W)
                    nx = mx + int'(sstep);
                if (!mair) begin
                    ny = land;
                    nvel = mvel;
                    nair = jump;
                    if (jump) nvel = -int'(sjump);
                end else begin
                    ysum = my + mvel;
                    ny = ysum;
                    nvel = mvel + 1;
                    nair = 1'b1;
                    if (ysum >= land) begin
                        ny = land;
                        nvel = 0;
                        nair = 1'b0;
                    end
                end
                mx <= nx;
                my <= ny;
                mvel <= nvel;
                mair <= nair;
                mog <= !nair;
            end
        end
    end

    // --------------------------------------------------
    // compare tasks
    // --------------------------------------------------
    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_pixel(input rgb_t got, input rgb_t exp);
        if (got !== exp)
            report_fail($sformatf("[ERROR] %0t rgb got %h exp %h", $time, got, exp));
    endtask

    task automatic check_sync(input logic h, input logic v, input logic eh, input logic ev);
        if (h !== eh) report_fail($sformatf("[ERROR] %0t hs got %b exp %b", $time, h, eh));
        if (v !== ev) report_fail($sformatf("[ERROR] %0t vs got %b exp %b", $time, v, ev));
    endtask

    task automatic check_pos(input logic [10:0] x, input logic [10:0] y, input logic og);
        if (x !== 11'(mx))
            report_fail($sformatf("[ERROR] %0t char_x got %0d exp %0d", $time, x, mx));
        if (y !== 11'(my))
            report_fail($sformatf("[ERROR] %0t char_y got %0d exp %0d", $time, y, my));
        if (og !== mog)
            report_fail($sformatf("[ERROR] %0t on_ground got %b exp %b", $time, og, mog));
    endtask

    task automatic check_rd(input string name, input wb_rsp_t rsp, input logic [31:0] exp);
        if (rsp.dat_r !== exp)
            report_fail($sformatf("[ERROR] %0t %s got %h exp %h", $time, name, rsp.dat_r, exp));
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            check_sync(hs, vs, s2.hsync, s2.vsync);
            check_pixel(rgb_t'({r, g, b}), s2.rgb);
            check_pos(char_x, char_y, on_ground);
        end
    end

    // --------------------------------------------------
    // bus and frame tasks
    // --------------------------------------------------
    task automatic wb_xfer(input logic we, input logic [3:0] adr, input logic [31:0] dat,
                           output wb_rsp_t rsp);
        int n;
        n = 0;
        @(posedge clk);
        wb_req <= '{1'b1, 1'b1, we, adr, dat};
        do begin
            @(posedge clk);
            n++;
            if (n > 16) report_fail("bus transfer was never acknowledged");
        end while (!wb_rsp.ack);
        rsp = wb_rsp;
        wb_req <= '0;
    endtask

    task automatic wb_write(input logic [3:0] adr, input logic [31:0] dat);
        wb_rsp_t rsp;
        wb_xfer(1'b1, adr, dat, rsp);
    endtask

    task automatic wb_read(input logic [3:0] adr, output wb_rsp_t rsp);
        wb_xfer(1'b0, adr, 32'd0, rsp);
    endtask

    task automatic read_expect(input string name, input logic [3:0] adr, input logic [31:0] exp);
        wb_rsp_t rsp;
        wb_read(adr, rsp);
        check_rd(name, rsp, exp);
    endtask

    // returns once the tick's position update has settled
    task automatic wait_tick();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > 2 * FRAME_LEN) report_fail("frame tick never came");
        end while (!mft);
        @(negedge clk);
    endtask

    task automatic set_buttons(input logic l, input logic rt, input logic j);
        @(posedge clk);
        left <= l;
        right <= rt;
        jump <= j;
    endtask

    task automatic check_status();
        read_expect("char_pos", 4'd6, {5'd0, 11'(my), 5'd0, 11'(mx)});
        read_expect("frame_cnt", 4'd7, 32'(mcnt));
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #(64'(N_FRAMES) * FRAME_LEN * 20 * 2);
        report_fail("watchdog expired before the tests finished");
    end

    initial begin
        logic [31:0] rv;
        rst_n = 1'b0;
        left = 1'b0;
        right = 1'b0;
        jump = 1'b0;
        wb_req = '0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        // reset values, unmapped reads, random write and readback
        read_expect("ctrl", 4'd0, 32'd0);
        for (int a = 1; a < 4; a++) read_expect("color", 4'(a), 32'd0);
        read_expect("ground_y", 4'd4, 32'd40);
        read_expect("motion", 4'd5, 32'h401);
        check_status();
        for (int a = 8; a < 16; a++) begin
            wb_write(4'(a), $random(seed));
            read_expect("unmapped", 4'(a), 32'd0);
        end
        for (int a = 1; a < 4; a++) begin
            rv = $random(seed);
            wb_write(4'(a), rv);
            read_expect("color", 4'(a), {20'd0, rv[11:0]});
        end
        rv = 32 + ($random(seed) & 7);
        wb_write(4'd4, rv);
        read_expect("ground_y", 4'd4, rv);
        wait_tick();
        wb_write(4'd0, 32'd1);
        read_expect("ctrl", 4'd0, 32'd1);
        // steps with clamping at both edges
        for (int f = 0; f < 30; f++) begin
            rv = $random(seed);
            if (f % 5 == 0) begin
                wb_write(4'd5, {20'd0, 4'd3, 4'd0, rv[11:8] | 4'd8});
                read_expect("motion", 4'd5, {20'd0, 4'd3, 4'd0, rv[11:8] | 4'd8});
            end
            if (f < 8) set_buttons(1'b1, 1'b0, 1'b0);
            else if (f < 20) set_buttons(1'b0, 1'b1, 1'b0);
            else set_buttons(rv[0], rv[1], 1'b0);
            wait_tick();
            check_status();
        end
        // jumps with gravity and landing
        for (int f = 0; f < 28; f++) begin
            rv = $random(seed);
            if (!mair && f % 4 == 0) begin
                wb_write(4'd5, {20'd0, 4'(rv[7:0] % 6 + 1), 4'd0, rv[11:8]});
                wb_write(4'd1 + 4'(rv[13:12] % 3), $random(seed));
            end
            set_buttons(rv[16], rv[17], rv[18] & rv[19]);
            wait_tick();
            check_status();
        end
        set_buttons(1'b0, 1'b0, 1'b0);
        for (int n = 0; n < 20 && !mog; n++) wait_tick();
        if (!mog) report_fail("character never landed");
        wb_write(4'd4, 32'd47);       // deeper ground while standing
        wait_tick();
        check_status();
        // run cleared so the position stays frozen
        wb_write(4'd0, 32'd0);
        for (int f = 0; f < 3; f++) begin
            rv = $random(seed);
            set_buttons(rv[0], rv[1], rv[2]);
            wait_tick();
            check_status();
        end
        $display("PASS: all tests");
        $finish;
    end

endmodule

// File: sim/top_vga_sva.sv
`timescale 1ns/1ps

module top_vga_sva (
    input logic             clk,
    input logic             rst_n,
    input vga_pkg::wb_req_t wb_req,
    input vga_pkg::wb_rsp_t wb_rsp,
    input logic             blank,
    input vga_pkg::rgb_t    rgb
);

    // single-cycle ack
    ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        wb_rsp.ack |=> !wb_rsp.ack)
        else $error("ack high two cycles in a row");

    ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb))
        else $error("ack without cyc and stb");

    // outputs black in blanking
    blank_black: assert property (@(posedge clk) disable iff (!rst_n)
        blank |-> (rgb == '0))
        else $error("colour during blanking");

endmodule

bind top_vga top_vga_sva u_sva (
    .clk(clk),
    .rst_n(rst_n),
    .wb_req(u_game_regs.wb_req),
    .wb_rsp(u_game_regs.wb_rsp),
    .blank(vga_char.hblnk || vga_char.vblnk),
    .rgb(vga_char.rgb)
);

// File: src/top_vga.sv
`timescale 1ns/1ps

module top_vga #(
    parameter int H_ACTIVE      = 800,
    parameter int H_FP          = 40,
    parameter int H_SYNC        = 128,
    parameter int H_BP          = 88,
    parameter int V_ACTIVE      = 600,
    parameter int V_FP          = 1,
    parameter int V_SYNC        = 4,
    parameter int V_BP          = 23,
    parameter int CHAR_W        = 32,
    parameter int CHAR_H        = 32,
    parameter int GROUND_Y_INIT = 480
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             stepleft,
    input  logic             stepright,
    input  logic             stepjump,
    input  vga_pkg::wb_req_t wb_req,
    output vga_pkg::wb_rsp_t wb_rsp,
    output logic             hs,
    output logic             vs,
    output logic [3:0]       r,
    output logic [3:0]       g,
    output logic [3:0]       b,
    output logic             on_ground,
    output logic [10:0]      char_x,
    output logic [10:0]      char_y
);
    import vga_pkg::*;

    vga_sig_t vga_tim;
    vga_sig_t vga_bg;
    vga_sig_t vga_char;
    cfg_t     cfg;
    logic     frame_tick;

    assign hs        = vga_char.hsync;
    assign vs        = vga_char.vsync;
    assign {r, g, b} = vga_char.rgb;

    // --------------------------------------------------
    // pixel pipeline
    // --------------------------------------------------
    vga_timing #(
        .H_ACTIVE(H_ACTIVE), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
        .V_ACTIVE(V_ACTIVE), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP)
    ) u_vga_timing (
        .clk(clk),
        .rst_n(rst_n),
        .vga_out(vga_tim),
        .frame_tick(frame_tick)
    );

    draw_bg u_draw_bg (
        .clk(clk),
        .rst_n(rst_n),
        .cfg(cfg),
        .vga_in(vga_tim),
        .vga_out(vga_bg)
    );

    draw_char #(
        .CHAR_W(CHAR_W),
        .CHAR_H(CHAR_H)
    ) u_draw_char (
        .clk(clk),
        .rst_n(rst_n),
        .cfg(cfg),
        .char_x(char_x),
        .char_y(char_y),
        .vga_in(vga_bg),
        .vga_out(vga_char)
    );

    // --------------------------------------------------
    // control side
    // --------------------------------------------------
    char_ctrl #(
        .H_ACTIVE(H_ACTIVE),
        .CHAR_W(CHAR_W),
        .CHAR_H(CHAR_H),
        .GROUND_Y_INIT(GROUND_Y_INIT)
    ) u_char_ctrl (
        .clk(clk),
        .rst_n(rst_n),
        .frame_tick(frame_tick),
        .cfg(cfg),
        .stepleft(stepleft),
        .stepright(stepright),
        .stepjump(stepjump),
        .char_x(char_x),
        .char_y(char_y),
        .on_ground(on_ground)
    );

    game_regs #(
        .GROUND_Y_INIT(GROUND_Y_INIT)
    ) u_game_regs (
        .clk(clk),
        .rst_n(rst_n),
        .wb_req(wb_req),
        .wb_rsp(wb_rsp),
        .frame_tick(frame_tick),
        .char_x(char_x),
        .char_y(char_y),
        .cfg(cfg)
    );

endmodule

// File: src/game_regs.sv
`timescale 1ns/1ps

module game_regs #(
    parameter int GROUND_Y_INIT = 480
) (
    input  logic             clk,
    input  logic             rst_n,
    input  vga_pkg::wb_req_t wb_req,
    output vga_pkg::wb_rsp_t wb_rsp,
    input  logic             frame_tick,
    input  logic [10:0]      char_x,
    input  logic [10:0]      char_y,
    output vga_pkg::cfg_t    cfg
);
    import vga_pkg::*;

    reg_addr_t   addr;
    logic        access;
    logic        wr_en;
    logic [31:0] rd_data;
    logic [31:0] frame_cnt;

    assign addr   = reg_addr_t'(wb_req.adr);
    assign access = wb_req.cyc && wb_req.stb && !wb_rsp.ack;
    assign wr_en  = access && wb_req.we;

    // --------------------------------------------------
    // read mux
    // --------------------------------------------------
    always_comb begin
        rd_data = '0;
        case (addr)
            REG_CTRL:         rd_data = {31'd0, cfg.run};
            REG_BG_COLOR:     rd_data = {20'd0, cfg.bg_color};
            REG_GROUND_COLOR: rd_data = {20'd0, cfg.ground_color};
            REG_CHAR_COLOR:   rd_data = {20'd0, cfg.char_color};
            REG_GROUND_Y:     rd_data = {21'd0, cfg.ground_y};
            REG_MOTION:       rd_data = {20'd0, cfg.jump, 4'd0, cfg.step};
            REG_CHAR_POS:     rd_data = {5'd0, char_y, 5'd0, char_x};
            REG_FRAME_CNT:    rd_data = frame_cnt;
            default:          rd_data = '0;   // unmapped
        endcase
    end

    // single-cycle ack, data held while ack is high
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_rsp <= '0;
        end else begin
            wb_rsp.ack <= access;
            if (access) begin
                wb_rsp.dat_r <= rd_data;
            end
        end
    end

    // --------------------------------------------------
    // writable registers
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg          <= '0;
            cfg.ground_y <= 11'(GROUND_Y_INIT);
            cfg.step     <= 4'd1;
            cfg.jump     <= 4'd4;
        end else if (wr_en) begin
            case (addr)
                REG_CTRL:         cfg.run          <= wb_req.dat_w[0];
                REG_BG_COLOR:     cfg.bg_color     <= wb_req.dat_w[11:0];
                REG_GROUND_COLOR: cfg.ground_color <= wb_req.dat_w[11:0];
                REG_CHAR_COLOR:   cfg.char_color   <= wb_req.dat_w[11:0];
                REG_GROUND_Y:     cfg.ground_y     <= wb_req.dat_w[10:0];
                REG_MOTION: begin
                    cfg.step <= wb_req.dat_w[3:0];
                    cfg.jump <= wb_req.dat_w[11:8];
                end
                default: ;                            // read only or unmapped
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frame_cnt <= '0;
        end else if (frame_tick) begin
            frame_cnt <= frame_cnt + 32'd1;
        end
    end

endmodule

// File: src/draw_char.sv
`timescale 1ns/1ps

module draw_char #(
    parameter int CHAR_W = 32,
    parameter int CHAR_H = 32
) (
    input  logic              clk,
    input  logic              rst_n,
    input  vga_pkg::cfg_t     cfg,
    input  logic [10:0]       char_x,
    input  logic [10:0]       char_y,
    input  vga_pkg::vga_sig_t vga_in,
    output vga_pkg::vga_sig_t vga_out
);
    import vga_pkg::*;

    logic [11:0] x_end;
    logic [11:0] y_end;
    logic        in_x;
    logic        in_y;
    logic        hit;
    rgb_t        rgb_nxt;

    // one past the last column and row of the rectangle
    assign x_end = {1'b0, char_x} + 12'(CHAR_W);
    assign y_end = {1'b0, char_y} + 12'(CHAR_H);

    assign in_x = (vga_in.hcount >= char_x) && ({1'b0, vga_in.hcount} < x_end);
    assign in_y = (vga_in.vcount >= char_y) && ({1'b0, vga_in.vcount} < y_end);
    assign hit  = cfg.run && !vga_in.hblnk && !vga_in.vblnk && in_x && in_y;

    assign rgb_nxt = hit ? cfg.char_color : vga_in.rgb;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vga_out <= '0;
        end else begin
            vga_out.hcount <= vga_in.hcount;
            vga_out.vcount <= vga_in.vcount;
            vga_out.hsync  <= vga_in.hsync;
            vga_out.vsync  <= vga_in.vsync;
            vga_out.hblnk  <= vga_in.hblnk;
            vga_out.vblnk  <= vga_in.vblnk;
            vga_out.rgb    <= rgb_nxt;     // solid rectangle on top
        end
    end

endmodule

// File: src/char_ctrl.sv
`timescale 1ns/1ps

module char_ctrl #(
    parameter int H_ACTIVE      = 800,
    parameter int CHAR_W        = 32,
    parameter int CHAR_H        = 32,
    parameter int GROUND_Y_INIT = 480
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          frame_tick,
    input  vga_pkg::cfg_t cfg,
    input  logic          stepleft,
    input  logic          stepright,
    input  logic          stepjump,
    output logic [10:0]   char_x,
    output logic [10:0]   char_y,
    output logic          on_ground
);
    import vga_pkg::*;

    localparam logic [11:0] X_MAX = 12'(H_ACTIVE - CHAR_W);

    motion_state_t       state, state_nxt;
    logic signed [7:0]   vel, vel_nxt;
    logic [10:0]         x_nxt, y_nxt;
    logic [10:0]         land_y;
    logic [11:0]         x_right;
    logic signed [12:0]  y_sum;

    // top of the character when standing on the ground line
    assign land_y  = (cfg.ground_y > 11'(CHAR_H)) ? cfg.ground_y - 11'(CHAR_H) : '0;
    assign x_right = {1'b0, char_x} + {8'd0, cfg.step};
    assign y_sum   = $signed({2'b00, char_y}) + 13'(vel);

    // --------------------------------------------------
    // per-frame motion rules
    // --------------------------------------------------
    always_comb begin
        x_nxt     = char_x;
        y_nxt     = char_y;
        vel_nxt   = vel;
        state_nxt = state;

        if (stepleft && !stepright && (char_x >= {7'd0, cfg.step})) begin
            x_nxt = char_x - {7'd0, cfg.step};
        end else if (stepright && !stepleft && (x_right <= X_MAX)) begin
            x_nxt = x_right[10:0];
        end

        if (state == MS_GROUND) begin
            y_nxt = land_y;                          // follows ground_y changes
            if (stepjump) begin
                vel_nxt   = -$signed({4'b0000, cfg.jump});
                state_nxt = MS_AIR;
            end
        end else begin
            vel_nxt = vel + 8'sd1;                   // gravity
            if (y_sum >= $signed({2'b00, land_y})) begin
                y_nxt     = land_y;
                vel_nxt   = '0;
                state_nxt = MS_GROUND;
            end else if (y_sum < 0) begin
                y_nxt = '0;                          // top edge
            end else begin
                y_nxt = y_sum[10:0];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            char_x    <= '0;
            char_y    <= 11'(GROUND_Y_INIT - CHAR_H);
            vel       <= '0;
            state     <= MS_GROUND;
            on_ground <= 1'b0;
        end else if (frame_tick && cfg.run) begin   // vertical blanking only
            char_x    <= x_nxt;
            char_y    <= y_nxt;
            vel       <= vel_nxt;
            state     <= state_nxt;
            on_ground <= (state_nxt == MS_GROUND);
        end
    end

endmodule

// File: src/draw_bg.sv
`timescale 1ns/1ps

module draw_bg (
    input  logic              clk,
    input  logic              rst_n,
    input  vga_pkg::cfg_t     cfg,
    input  vga_pkg::vga_sig_t vga_in,
    output vga_pkg::vga_sig_t vga_out
);
    import vga_pkg::*;

    rgb_t rgb_nxt;
    logic blank;

    assign blank = vga_in.hblnk || vga_in.vblnk;

    // --------------------------------------------------
    // sky above the ground line, ground at and below it
    // --------------------------------------------------
    always_comb begin
        if (blank) begin
            rgb_nxt = '0;
        end else if (vga_in.vcount >= cfg.ground_y) begin
            rgb_nxt = cfg.ground_color;
        end else begin
            rgb_nxt = cfg.bg_color;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vga_out <= '0;
        end else begin
            vga_out.hcount <= vga_in.hcount;
            vga_out.vcount <= vga_in.vcount;
            vga_out.hsync  <= vga_in.hsync;
            vga_out.vsync  <= vga_in.vsync;
            vga_out.hblnk  <= vga_in.hblnk;
            vga_out.vblnk  <= vga_in.vblnk;
            vga_out.rgb    <= rgb_nxt;
        end
    end

endmodule

// File: src/vga_timing.sv
`timescale 1ns/1ps

module vga_timing #(
    parameter int H_ACTIVE = 800,
    parameter int H_FP     = 40,
    parameter int H_SYNC   = 128,
    parameter int H_BP     = 88,
    parameter int V_ACTIVE = 600,
    parameter int V_FP     = 1,
    parameter int V_SYNC   = 4,
    parameter int V_BP     = 23
) (
    input  logic              clk,
    input  logic              rst_n,
    output vga_pkg::vga_sig_t vga_out,
    output logic              frame_tick
);

    localparam int H_TOTAL = H_ACTIVE + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL = V_ACTIVE + V_FP + V_SYNC + V_BP;

    localparam logic [10:0] H_LAST   = 11'(H_TOTAL - 1);
    localparam logic [10:0] V_LAST   = 11'(V_TOTAL - 1);
    localparam logic [10:0] HS_START = 11'(H_ACTIVE + H_FP);
    localparam logic [10:0] HS_END   = 11'(H_ACTIVE + H_FP + H_SYNC);
    localparam logic [10:0] VS_START = 11'(V_ACTIVE + V_FP);
    localparam logic [10:0] VS_END   = 11'(V_ACTIVE + V_FP + V_SYNC);

    logic [10:0] h_nxt;
    logic [10:0] v_nxt;

    // --------------------------------------------------
    // next counter values
    // --------------------------------------------------
    always_comb begin
        if (vga_out.hcount == H_LAST) begin
            h_nxt = '0;
            if (vga_out.vcount == V_LAST) begin
                v_nxt = '0;             // wrap to next frame
            end else begin
                v_nxt = vga_out.vcount + 11'd1;
            end
        end else begin
            h_nxt = vga_out.hcount + 11'd1;
            v_nxt = vga_out.vcount;
        end
    end

    // sync and blanking decoded from next count, so they line up with counters
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vga_out    <= '0;
            frame_tick <= 1'b0;
        end else begin
            vga_out.hcount <= h_nxt;
            vga_out.vcount <= v_nxt;
            vga_out.hsync  <= (h_nxt >= HS_START) && (h_nxt < HS_END);
            vga_out.vsync  <= (v_nxt >= VS_START) && (v_nxt < VS_END);
            vga_out.hblnk  <= (h_nxt >= 11'(H_ACTIVE));
            vga_out.vblnk  <= (v_nxt >= 11'(V_ACTIVE));
            vga_out.rgb    <= '0;
            frame_tick     <= (h_nxt == 11'd0) && (v_nxt == 11'(V_ACTIVE));  // first blank line
        end
    end

endmodule

// File: src/vga_pkg.sv
package vga_pkg;

    // --------------------------------------------------
    // pixel bundle
    // --------------------------------------------------
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    typedef struct packed {
        logic [10:0] hcount;
        logic [10:0] vcount;
        logic        hsync;
        logic        vsync;
        logic        hblnk;
        logic        vblnk;
        rgb_t        rgb;
    } vga_sig_t;

    // --------------------------------------------------
    // wishbone classic
    // --------------------------------------------------
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  adr;     // word address
        logic [31:0] dat_w;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat_r;
    } wb_rsp_t;

    typedef enum logic [3:0] {
        REG_CTRL         = 4'd0,
        REG_BG_COLOR     = 4'd1,
        REG_GROUND_COLOR = 4'd2,
        REG_CHAR_COLOR   = 4'd3,
        REG_GROUND_Y     = 4'd4,
        REG_MOTION       = 4'd5,
        REG_CHAR_POS     = 4'd6,   // read only
        REG_FRAME_CNT    = 4'd7    // read only
    } reg_addr_t;

    typedef enum logic {
        MS_GROUND = 1'b0,
        MS_AIR    = 1'b1
    } motion_state_t;

    typedef struct packed {
        logic        run;
        rgb_t        bg_color;
        rgb_t        ground_color;
        rgb_t        char_color;
        logic [10:0] ground_y;
        logic [3:0]  step;
        logic [3:0]  jump;
    } cfg_t;

endpackage
